// ==== mu_pkg.sv ====
package mu_pkg;

   // ##########################################################
   // widths shared by the memory unit.
   // ##########################################################

   localparam int unsigned MU_WORD_W = 32;

   // the bank index field is wide enough for up to 256 banks.
   localparam int unsigned MU_BANK_SEL_W = 8;

   // ##########################################################
   // opcodes and states.
   // ##########################################################

   typedef enum logic [2:0] {
      MU_LB  = 3'd0,
      MU_LBU = 3'd1,
      MU_LH  = 3'd2,
      MU_LHU = 3'd3,
      MU_LW  = 3'd4,
      MU_SB  = 3'd5,
      MU_SH  = 3'd6,
      MU_SW  = 3'd7
   } mu_op_e;

   typedef enum logic [1:0] {
      IDLE = 2'd0,
      REQ  = 2'd1,
      WAIT = 2'd2
   } mu_issue_state_e;

   // ##########################################################
   // structs carried between the blocks.
   // ##########################################################

   // one operation from the execute stage.
   typedef struct packed {
      mu_op_e               op;
      logic [MU_WORD_W-1:0] base;
      logic [MU_WORD_W-1:0] offset;
      logic [MU_WORD_W-1:0] wdata;
   } mu_op_t;

   // one request to a bank with the store data already in lane position.
   typedef struct packed {
      logic                 we;
      logic [3:0]           be;
      logic [MU_WORD_W-1:0] word_addr;
      logic [MU_WORD_W-1:0] wdata;
   } mu_req_t;

   // what the merge block needs to finish a load or a fault.
   typedef struct packed {
      mu_op_e                   op;
      logic [1:0]               byte_off;
      logic [MU_BANK_SEL_W-1:0] bank;
      logic                     fault;
   } mu_tag_t;

   // one result for write-back.
   typedef struct packed {
      logic [MU_WORD_W-1:0] data;
      logic                 fault;
      logic [MU_WORD_W-1:0] addr;
   } mu_wb_t;

endpackage

// ==== mu_issue.sv ====
`timescale 1ns/1ps

module mu_issue #(
   parameter int unsigned NUM_BANKS = 4
) (
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  logic                 op_valid_i,
   input  mu_pkg::mu_op_t       op_i,
   output logic                 op_ready_o,
   output logic [NUM_BANKS-1:0] bank_req_valid_o,
   output mu_pkg::mu_req_t      bank_req_o,
   input  logic [NUM_BANKS-1:0] bank_req_ready_i,
   output logic                 tag_valid_o,
   output mu_pkg::mu_tag_t      tag_o,
   output logic [31:0]          addr_o,
   input  logic                 done_i
);

   import mu_pkg::*;

   mu_issue_state_e          state_q;
   mu_op_t                   op_q;
   logic                     req_valid_q;
   mu_req_t                  req_q;
   logic [MU_BANK_SEL_W-1:0] bank_q;

   logic [31:0]              addr;
   logic [31:0]              word_addr;
   logic [1:0]               byte_off;
   logic [MU_BANK_SEL_W-1:0] bank_sel;
   logic                     is_store;
   logic                     misaligned;
   logic [3:0]               be;
   logic [31:0]              lane_wdata;
   logic                     req_accept;
   logic                     issue_now;

   // ##########################################################
   // address, alignment and lane setup from the held operation.
   // ##########################################################

   assign addr      = op_q.base + op_q.offset;
   assign word_addr = {2'b00, addr[31:2]};
   assign byte_off  = addr[1:0];
   assign is_store  = (op_q.op == MU_SB) || (op_q.op == MU_SH) || (op_q.op == MU_SW);

   // the banks are interleaved, so the low word bits pick the bank.
   assign bank_sel = word_addr[MU_BANK_SEL_W-1:0] & MU_BANK_SEL_W'(NUM_BANKS - 1);

   always_comb begin
      misaligned = 1'b0;
      be         = 4'b1111;
      lane_wdata = op_q.wdata;
      case (op_q.op)
         MU_LB, MU_LBU, MU_SB: begin
            be         = 4'b0001 << byte_off;
            lane_wdata = {4{op_q.wdata[7:0]}};
         end
         MU_LH, MU_LHU, MU_SH: begin
            misaligned = byte_off[0];
            be         = 4'b0011 << byte_off;
            lane_wdata = {2{op_q.wdata[15:0]}};
         end
         default: begin
            misaligned = (byte_off != 2'b00);
         end
      endcase
   end

   // ##########################################################
   // control.
   // ##########################################################

   assign op_ready_o = (state_q == IDLE);
   assign issue_now  = (state_q == REQ) && !req_valid_q;
   assign req_accept = req_valid_q && (|(bank_req_valid_o & bank_req_ready_i));

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q     <= IDLE;
         req_valid_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (op_valid_i) begin
                  state_q <= REQ;
               end
            end
            REQ: begin
               if (issue_now) begin
                  // a misaligned access never reaches a bank.
                  if (misaligned) begin
                     state_q <= WAIT;
                  end else begin
                     req_valid_q <= 1'b1;
                  end
               end else if (req_accept) begin
                  req_valid_q <= 1'b0;
                  state_q     <= is_store ? IDLE : WAIT;
               end
            end
            WAIT: begin
               if (done_i) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (op_valid_i && op_ready_o) begin
         op_q <= op_i;
      end
      if (issue_now) begin
         req_q  <= '{we: is_store, be: be, word_addr: word_addr, wdata: lane_wdata};
         bank_q <= bank_sel;
      end
   end

   always_comb begin
      for (int k = 0; k < NUM_BANKS; k++) begin
         bank_req_valid_o[k] = req_valid_q && (bank_q == MU_BANK_SEL_W'(k));
      end
   end

   assign bank_req_o = req_q;

   // loads and faults hand their tag over in the first REQ cycle.
   assign tag_valid_o = issue_now && (misaligned || !is_store);
   assign tag_o       = '{op: op_q.op, byte_off: byte_off, bank: bank_sel, fault: misaligned};
   assign addr_o      = addr;

   // ##########################################################
   // checks.
   // ##########################################################

   // a bank request belongs to the one operation in flight.
   a_one_in_flight: assert property (@(posedge clk) disable iff (!arst_n_i)
      (|bank_req_valid_o) |-> (state_q == REQ) && !done_i);

   a_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
      (|bank_req_valid_o) && !(|(bank_req_valid_o & bank_req_ready_i))
      |=> $stable(bank_req_valid_o) && $stable(bank_req_o));

endmodule

// ==== mu_bank.sv ====
`timescale 1ns/1ps

module mu_bank #(
   parameter int unsigned NUM_BANKS  = 4,
   parameter int unsigned BANK_WORDS = 64
) (
   input  logic            clk,
   input  logic            arst_n_i,
   input  logic            req_valid_i,
   input  mu_pkg::mu_req_t req_i,
   output logic            req_ready_o,
   output logic            rsp_valid_o,
   output logic [31:0]     rsp_data_o,
   input  logic            rsp_ready_i
);

   import mu_pkg::*;

   // the low word bits select the bank, the next bits the row.
   localparam int unsigned BANK_SHIFT = $clog2(NUM_BANKS);
   localparam int unsigned ROW_W      = $clog2(BANK_WORDS);

   logic [MU_WORD_W-1:0] mem [BANK_WORDS];

   logic [ROW_W-1:0]     row;
   logic                 req_fire;
   logic                 wr_en;
   logic                 rd_en;
   logic                 rsp_valid_q;
   logic [MU_WORD_W-1:0] rsp_data_q;

   assign row         = req_i.word_addr[ROW_W+BANK_SHIFT-1:BANK_SHIFT];
   // a pending read response blocks new requests.
   assign req_ready_o = !rsp_valid_q;
   assign req_fire    = req_valid_i && req_ready_o;
   assign wr_en       = req_fire && req_i.we;
   assign rd_en       = req_fire && !req_i.we;

   // ##########################################################
   // storage and read data.
   // ##########################################################

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < 4; b++) begin
            if (req_i.be[b]) begin
               mem[row][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
            end
         end
      end
      if (rd_en) begin
         rsp_data_q <= mem[row];
      end
   end

   // ##########################################################
   // response handshake.
   // ##########################################################

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rsp_valid_q <= 1'b0;
      end else if (rd_en) begin
         rsp_valid_q <= 1'b1;
      end else if (rsp_valid_q && rsp_ready_i) begin
         rsp_valid_q <= 1'b0;
      end
   end

   assign rsp_valid_o = rsp_valid_q;
   assign rsp_data_o  = rsp_data_q;

   a_store_no_rsp: assert property (@(posedge clk) disable iff (!arst_n_i)
      req_valid_i && req_i.we |=> !rsp_valid_o);

endmodule

// ==== mu_resp_merge.sv ====
`timescale 1ns/1ps

module mu_resp_merge #(
   parameter int unsigned NUM_BANKS = 4
) (
   input  logic                       clk,
   input  logic                       arst_n_i,
   input  logic                       tag_valid_i,
   input  mu_pkg::mu_tag_t            tag_i,
   input  logic [31:0]                addr_i,
   output logic                       done_o,
   input  logic [NUM_BANKS-1:0]       bank_rsp_valid_i,
   input  logic [NUM_BANKS-1:0][31:0] bank_rsp_data_i,
   output logic [NUM_BANKS-1:0]       bank_rsp_ready_o,
   output logic                       wb_valid_o,
   output mu_pkg::mu_wb_t             wb_o,
   input  logic                       wb_ready_i
);

   import mu_pkg::*;

   logic                 pend_q;
   mu_tag_t              tag_q;
   logic [31:0]          addr_q;
   logic                 wb_valid_q;
   mu_wb_t               wb_q;

   logic                 rsp_take;
   logic [MU_WORD_W-1:0] rsp_word;
   logic [MU_WORD_W-1:0] shifted;
   logic [MU_WORD_W-1:0] load_data;

   // ##########################################################
   // bank response select.
   // ##########################################################

   always_comb begin
      rsp_word = '0;
      for (int k = 0; k < NUM_BANKS; k++) begin
         bank_rsp_ready_o[k] = pend_q && (tag_q.bank == MU_BANK_SEL_W'(k));
         if (bank_rsp_ready_o[k]) begin
            rsp_word = bank_rsp_data_i[k];
         end
      end
   end

   assign rsp_take = |(bank_rsp_valid_i & bank_rsp_ready_o);

   // move the addressed lane down, then extend.
   assign shifted = rsp_word >> {tag_q.byte_off, 3'b000};

   always_comb begin
      case (tag_q.op)
         MU_LB:   load_data = {{24{shifted[7]}}, shifted[7:0]};
         MU_LBU:  load_data = {24'd0, shifted[7:0]};
         MU_LH:   load_data = {{16{shifted[15]}}, shifted[15:0]};
         MU_LHU:  load_data = {16'd0, shifted[15:0]};
         default: load_data = rsp_word;
      endcase
   end

   // ##########################################################
   // write-back register.
   // ##########################################################

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pend_q     <= 1'b0;
         wb_valid_q <= 1'b0;
      end else begin
         if (tag_valid_i) begin
            pend_q     <= !tag_i.fault;
            wb_valid_q <= tag_i.fault;
         end else if (rsp_take) begin
            pend_q     <= 1'b0;
            wb_valid_q <= 1'b1;
         end else if (done_o) begin
            wb_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tag_valid_i) begin
         tag_q  <= tag_i;
         addr_q <= addr_i;
         if (tag_i.fault) begin
            wb_q <= '{data: '0, fault: 1'b1, addr: addr_i};
         end
      end else if (rsp_take) begin
         wb_q <= '{data: load_data, fault: 1'b0, addr: addr_q};
      end
   end

   assign wb_valid_o = wb_valid_q;
   assign wb_o       = wb_q;
   assign done_o     = wb_valid_q && wb_ready_i;

   a_wb_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
      wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o));

endmodule

// ==== mu_top.sv ====
`timescale 1ns/1ps

module mu_top #(
   parameter int unsigned NUM_BANKS  = 4,
   parameter int unsigned BANK_WORDS = 64
) (
   input  logic           clk,
   input  logic           arst_n_i,
   input  logic           op_valid_i,
   input  mu_pkg::mu_op_t op_i,
   output logic           op_ready_o,
   output logic           wb_valid_o,
   output mu_pkg::mu_wb_t wb_o,
   input  logic           wb_ready_i
);

   import mu_pkg::*;

   logic [NUM_BANKS-1:0]       bank_req_valid;
   mu_req_t                    bank_req;
   logic [NUM_BANKS-1:0]       bank_req_ready;
   logic [NUM_BANKS-1:0]       bank_rsp_valid;
   logic [NUM_BANKS-1:0][31:0] bank_rsp_data;
   logic [NUM_BANKS-1:0]       bank_rsp_ready;

   logic                       tag_valid;
   mu_tag_t                    tag;
   logic [31:0]                addr;
   logic                       done;

   // ##########################################################
   // issue, banks and merge.
   // ##########################################################

   mu_issue #(
      .NUM_BANKS (NUM_BANKS)
   ) i_issue (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .op_valid_i       (op_valid_i),
      .op_i             (op_i),
      .op_ready_o       (op_ready_o),
      .bank_req_valid_o (bank_req_valid),
      .bank_req_o       (bank_req),
      .bank_req_ready_i (bank_req_ready),
      .tag_valid_o      (tag_valid),
      .tag_o            (tag),
      .addr_o           (addr),
      .done_i           (done)
   );

   // every bank sees the shared request and only one gets valid.
   for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
      mu_bank #(
         .NUM_BANKS  (NUM_BANKS),
         .BANK_WORDS (BANK_WORDS)
      ) i_bank (
         .clk         (clk),
         .arst_n_i    (arst_n_i),
         .req_valid_i (bank_req_valid[k]),
         .req_i       (bank_req),
         .req_ready_o (bank_req_ready[k]),
         .rsp_valid_o (bank_rsp_valid[k]),
         .rsp_data_o  (bank_rsp_data[k]),
         .rsp_ready_i (bank_rsp_ready[k])
      );
   end

   mu_resp_merge #(
      .NUM_BANKS (NUM_BANKS)
   ) i_resp_merge (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .tag_valid_i      (tag_valid),
      .tag_i            (tag),
      .addr_i           (addr),
      .done_o           (done),
      .bank_rsp_valid_i (bank_rsp_valid),
      .bank_rsp_data_i  (bank_rsp_data),
      .bank_rsp_ready_o (bank_rsp_ready),
      .wb_valid_o       (wb_valid_o),
      .wb_o             (wb_o),
      .wb_ready_i       (wb_ready_i)
   );

endmodule

// ==== tb_mu_top.sv ====
`timescale 1ns/1ps

module tb_mu_top;

   import mu_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int MEM_BYTES  = 1024;

   logic   clk;
   logic   arst_n_i;
   logic   op_valid_i;
   mu_op_t op_i;
   logic   op_ready_o;
   logic   wb_valid_o;
   mu_wb_t wb_o;
   logic   wb_ready_i;

   // the stimulus table holds one index per test.
   string       name_tbl[$];
   mu_op_t      op_tbl[$];
   int          stall_tbl[$];
   logic [31:0] exp_data_tbl[$];
   logic        exp_fault_tbl[$];

   logic [7:0]  ref_mem [MEM_BYTES];
   int          seed = 7;
   int          test_errs;
   int          pass_cnt;
   int          fail_cnt;
   logic        table_ready = 1'b0;

   mu_top i_dut (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .op_valid_i (op_valid_i),
      .op_i       (op_i),
      .op_ready_o (op_ready_o),
      .wb_valid_o (wb_valid_o),
      .wb_o       (wb_o),
      .wb_ready_i (wb_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ##########################################################
   // reference model of the byte memory.
   // ##########################################################

   function automatic logic misaligned_access(mu_op_e op, logic [31:0] addr);
      case (op)
         MU_LH, MU_LHU, MU_SH: return addr[0];
         MU_LW, MU_SW:         return addr[1:0] != 2'b00;
         default:              return 1'b0;
      endcase
   endfunction

   function automatic logic is_store_op(mu_op_e op);
      return (op == MU_SB) || (op == MU_SH) || (op == MU_SW);
   endfunction

   function automatic logic [31:0] ref_load(mu_op_e op, logic [31:0] addr);
      int          idx;
      logic [15:0] half;
      idx  = addr % MEM_BYTES;
      half = {ref_mem[(idx + 1) % MEM_BYTES], ref_mem[idx]};
      case (op)
         MU_LB:   return {{24{ref_mem[idx][7]}}, ref_mem[idx]};
         MU_LBU:  return {24'd0, ref_mem[idx]};
         MU_LH:   return {{16{half[15]}}, half};
         MU_LHU:  return {16'd0, half};
         default: return {ref_mem[(idx + 3) % MEM_BYTES], ref_mem[(idx + 2) % MEM_BYTES], half};
      endcase
   endfunction

   task automatic ref_store(mu_op_e op, logic [31:0] addr, logic [31:0] wdata);
      int n;
      int idx;
      idx = addr % MEM_BYTES;
      n   = (op == MU_SB) ? 1 : (op == MU_SH) ? 2 : 4;
      for (int b = 0; b < n; b++) begin
         ref_mem[(idx + b) % MEM_BYTES] = wdata[b*8 +: 8];
      end
   endtask

   // ##########################################################
   // table setup.
   // ##########################################################

   task automatic add_entry(string name, mu_op_e op, logic [31:0] base, logic [31:0] offset,
                            logic [31:0] wdata, int stall);
      mu_op_t e;
      e = '{op: op, base: base, offset: offset, wdata: wdata};
      name_tbl.push_back(name);
      op_tbl.push_back(e);
      stall_tbl.push_back(stall);
      exp_data_tbl.push_back('0);
      exp_fault_tbl.push_back(1'b0);
   endtask

   // walk the table in order so loads see every earlier store.
   task automatic fill_expected();
      logic [31:0] addr;
      for (int i = 0; i < op_tbl.size(); i++) begin
         addr             = op_tbl[i].base + op_tbl[i].offset;
         exp_fault_tbl[i] = misaligned_access(op_tbl[i].op, addr);
         if (exp_fault_tbl[i]) begin
            exp_data_tbl[i] = '0;
         end else if (is_store_op(op_tbl[i].op)) begin
            ref_store(op_tbl[i].op, addr, op_tbl[i].wdata);
         end else begin
            exp_data_tbl[i] = ref_load(op_tbl[i].op, addr);
         end
      end
   endtask

   task automatic build_table();
      for (int k = 0; k < 8; k++) begin
         add_entry($sformatf("sw_sweep%0d", k), MU_SW, 32'h100, k * 4, $random(seed), 0);
      end
      for (int k = 0; k < 8; k++) begin
         add_entry($sformatf("lw_sweep%0d", k), MU_LW, 32'h0F0, 32'h10 + k * 4, '0, 0);
      end
      add_entry("merge_sw", MU_SW, 32'h200, 0, 32'h11223344, 0);
      add_entry("merge_sb", MU_SB, 32'h200, 1, 32'h000000AB, 0);
      add_entry("merge_sh", MU_SH, 32'h1FE, 4, 32'h0000CDEF, 0);
      add_entry("merge_lw", MU_LW, 32'h200, 0, '0, 0);
      add_entry("sext_sw", MU_SW, 32'h240, 0, 32'h8899F0A5, 0);
      add_entry("lb_low", MU_LB, 32'h240, 0, '0, 0);
      add_entry("lbu_low", MU_LBU, 32'h240, 0, '0, 0);
      add_entry("lb_top", MU_LB, 32'h240, 3, '0, 0);
      add_entry("lbu_top", MU_LBU, 32'h240, 3, '0, 0);
      add_entry("lh_low", MU_LH, 32'h240, 0, '0, 0);
      add_entry("lhu_low", MU_LHU, 32'h240, 0, '0, 0);
      add_entry("lh_top", MU_LH, 32'h23E, 4, '0, 0);
      add_entry("lhu_top", MU_LHU, 32'h23E, 4, '0, 0);
      add_entry("mis_sw0", MU_SW, 32'h280, 0, 32'hDEADBEEF, 0);
      add_entry("mis_sw1", MU_SW, 32'h280, 4, 32'h0BADF00D, 0);
      add_entry("mis_lh", MU_LH, 32'h280, 1, '0, 0);
      add_entry("mis_lw", MU_LW, 32'h280, 2, '0, 0);
      add_entry("mis_sw", MU_SW, 32'h284, 2, 32'hFFFFFFFF, 0);
      add_entry("mis_chk0", MU_LW, 32'h280, 0, '0, 0);
      add_entry("mis_chk1", MU_LW, 32'h280, 4, '0, 0);
      add_entry("bp_lw", MU_LW, 32'h200, 0, '0, 5);
      add_entry("bp_lb", MU_LB, 32'h240, 0, '0, 3);
      add_entry("bp_fault", MU_LW, 32'h281, 0, '0, 4);
   endtask

   // ##########################################################
   // driving and checking.
   // ##########################################################

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic check_value(string test, string field, logic [31:0] expected,
                              logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERROR: %s %s expected %h actual %h", test, field, expected, actual);
         test_errs++;
      end
   endtask

   task automatic run_entry(int i);
      mu_wb_t snap;
      mu_wb_t got;
      logic   need_wb;
      need_wb = exp_fault_tbl[i] || !is_store_op(op_tbl[i].op);
      op_valid_i = 1'b1;
      op_i       = op_tbl[i];
      while (!op_ready_o) begin
         next_cycle();
      end
      next_cycle();
      op_valid_i = 1'b0;
      if (stall_tbl[i] > 0) begin
         wb_ready_i = 1'b0;
      end
      if (need_wb) begin
         while (!wb_valid_o) begin
            next_cycle();
         end
         snap = wb_o;
         for (int s = 0; s < stall_tbl[i]; s++) begin
            next_cycle();
            check_value(name_tbl[i], "held valid", 32'd1, {31'd0, wb_valid_o});
            check_value(name_tbl[i], "held data", snap.data, wb_o.data);
            check_value(name_tbl[i], "held fault", {31'd0, snap.fault}, {31'd0, wb_o.fault});
            check_value(name_tbl[i], "held addr", snap.addr, wb_o.addr);
            check_value(name_tbl[i], "op_ready", 32'd0, {31'd0, op_ready_o});
         end
         wb_ready_i = 1'b1;
         got = wb_o;
         next_cycle();
         check_value(name_tbl[i], "data", exp_data_tbl[i], got.data);
         check_value(name_tbl[i], "fault", {31'd0, exp_fault_tbl[i]}, {31'd0, got.fault});
         check_value(name_tbl[i], "addr", op_tbl[i].base + op_tbl[i].offset, got.addr);
      end
   endtask

   task automatic finish_test(string name);
      if (test_errs == 0) begin
         pass_cnt++;
         $display("test %-10s ok", name);
      end else begin
         fail_cnt++;
         $display("test %-10s failed", name);
      end
   endtask

   initial begin
      arst_n_i   = 1'b0;
      op_valid_i = 1'b0;
      op_i       = '0;
      wb_ready_i = 1'b1;
      pass_cnt   = 0;
      fail_cnt   = 0;
      build_table();
      fill_expected();
      table_ready = 1'b1;
      repeat (3) @(posedge clk);
      #2;
      arst_n_i = 1'b1;
      next_cycle();
      test_errs = 0;
      check_value("reset", "op_ready", 32'd1, {31'd0, op_ready_o});
      check_value("reset", "wb_valid", 32'd0, {31'd0, wb_valid_o});
      finish_test("reset");
      for (int i = 0; i < op_tbl.size(); i++) begin
         test_errs = 0;
         run_entry(i);
         finish_test(name_tbl[i]);
      end
      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // the watchdog allows 40 cycles per table entry plus the reset.
   initial begin
      wait (table_ready);
      #(op_tbl.size() * 40 * CLK_PERIOD + 3 * CLK_PERIOD);
      $display("timeout: the run hung before all tests finished");
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== sources.f ====
mu_pkg.sv
mu_issue.sv
mu_bank.sv
mu_resp_merge.sv
mu_top.sv
tb_mu_top.sv

// ==== Bender.yml ====
package:
  name: mu_subsystem

sources:
  - files:
      - mu_pkg.sv
      - mu_issue.sv
      - mu_bank.sv
      - mu_resp_merge.sv
      - mu_top.sv
  - target: test
    files:
      - tb_mu_top.sv
